/* src.f */
+incdir+hw
hw/axil_ram_pkg.sv
hw/axil_if.sv
hw/ram_port_if.sv
hw/axil_ram_port.sv
hw/dp_ram_core.sv
hw/axil_dp_ram.sv
tests/tb_clock.sv
tests/tb_axil_dp_ram.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_axil_dp_ram -o sim_axil_dp_ram
out=$(./obj_dir/sim_axil_dp_ram)
echo "$out"
if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

/* tests/tb_axil_dp_ram.sv */
// Directed testbench for the dual-port AXI4-Lite RAM; built and run by run.sh
module tb_axil_dp_ram;
    import axil_ram_pkg::*;

    localparam int wait_limit = 20;

    logic a_clk;
    logic a_rst;
    axil_addr_t awaddr [2];
    axil_addr_t araddr [2];
    axil_data_t wdata [2];
    axil_data_t rdata [2];
    axil_strb_t wstrb [2];
    axil_resp_t bresp [2];
    axil_resp_t rresp [2];
    logic awvalid [2];
    logic awready [2];
    logic wvalid [2];
    logic wready [2];
    logic bvalid [2];
    logic bready [2];
    logic arvalid [2];
    logic arready [2];
    logic rvalid [2];
    logic rready [2];

    // reference memory and the expected arbitration state per port
    axil_data_t model [2 ** $bits(mem_index_t)];
    logic last_read [2];
    logic [31:0] lfsr_state = 32'h47e1;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    tb_clock i_tb_clock (
        .a_clk(a_clk)
    );

    axil_dp_ram i_axil_dp_ram (
        .a_clk(a_clk), .a_rst(a_rst),
        .a_awaddr(awaddr[0]), .b_awaddr(awaddr[1]),
        .a_awvalid(awvalid[0]), .b_awvalid(awvalid[1]),
        .a_awready(awready[0]), .b_awready(awready[1]),
        .a_wdata(wdata[0]), .b_wdata(wdata[1]),
        .a_wstrb(wstrb[0]), .b_wstrb(wstrb[1]),
        .a_wvalid(wvalid[0]), .b_wvalid(wvalid[1]),
        .a_wready(wready[0]), .b_wready(wready[1]),
        .a_bresp(bresp[0]), .b_bresp(bresp[1]),
        .a_bvalid(bvalid[0]), .b_bvalid(bvalid[1]),
        .a_bready(bready[0]), .b_bready(bready[1]),
        .a_araddr(araddr[0]), .b_araddr(araddr[1]),
        .a_arvalid(arvalid[0]), .b_arvalid(arvalid[1]),
        .a_arready(arready[0]), .b_arready(arready[1]),
        .a_rdata(rdata[0]), .b_rdata(rdata[1]),
        .a_rresp(rresp[0]), .b_rresp(rresp[1]),
        .a_rvalid(rvalid[0]), .b_rvalid(rvalid[1]),
        .a_rready(rready[0]), .b_rready(rready[1])
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // four byte lanes per word, low two address bits ignored
    function automatic mem_index_t word_index(axil_addr_t addr);
        return mem_index_t'(addr >> 2);
    endfunction

    function automatic void model_write(axil_addr_t addr, axil_data_t data, axil_strb_t strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                model[word_index(addr)][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    task automatic check_value(string name, int p, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error: port %0d %s = %h, expected %h", p, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic timeout_fail(string what, int p);
        $display("timeout on port %0d while waiting for %s", p, what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic start_write(int p, axil_addr_t addr, axil_data_t data, axil_strb_t strb);
        awaddr[p] <= addr;
        wdata[p] <= data;
        wstrb[p] <= strb;
        awvalid[p] <= 1'b1;
        wvalid[p] <= 1'b1;
    endtask

    task automatic start_read(int p, axil_addr_t addr);
        araddr[p] <= addr;
        arvalid[p] <= 1'b1;
    endtask

    // waits for the accept pulse, then drops the valids on the next edge
    task automatic finish_write(int p);
        int n;
        n = 0;
        do begin
            @(negedge a_clk);
            n++;
            if (n > wait_limit) begin
                timeout_fail("write accept", p);
            end
        end while (!awready[p]);
        check_true(wready[p] && bvalid[p], "wready or bvalid missing alongside awready");
        check_value("bresp", p, 32'(bresp[p]), 32'h0);
        model_write(awaddr[p], wdata[p], wstrb[p]);
        last_read[p] = 1'b0;
        @(posedge a_clk);
        awvalid[p] <= 1'b0;
        wvalid[p] <= 1'b0;
    endtask

    task automatic finish_read(int p, output axil_data_t data);
        int n;
        logic seen_ar;
        logic got;
        n = 0;
        seen_ar = 1'b0;
        got = 1'b0;
        do begin
            @(negedge a_clk);
            n++;
            if (n > wait_limit) begin
                timeout_fail("read data", p);
            end
            seen_ar = seen_ar || arready[p];
            if (rvalid[p]) begin
                data = rdata[p];
                got = 1'b1;
                check_value("rresp", p, 32'(rresp[p]), 32'h0);
            end
            @(posedge a_clk);
            if (seen_ar) begin
                arvalid[p] <= 1'b0;
            end
        end while (!got);
        last_read[p] = 1'b1;
    endtask

    task automatic axil_write(int p, axil_addr_t addr, axil_data_t data, axil_strb_t strb);
        @(posedge a_clk);
        start_write(p, addr, data, strb);
        finish_write(p);
    endtask

    task automatic axil_read(int p, axil_addr_t addr);
        axil_data_t data;
        @(posedge a_clk);
        start_read(p, addr);
        finish_read(p, data);
        check_value("rdata", p, data, model[word_index(addr)]);
    endtask

    task automatic run_op(int p, logic is_write, axil_addr_t addr, axil_data_t data,
                          axil_strb_t strb);
        if (is_write) begin
            axil_write(p, addr, data, strb);
        end else begin
            axil_read(p, addr);
        end
    endtask

    task automatic report(string name, int errors_before);
        tests++;
        $display("test %-12s %s", name, errors == errors_before ? "ok" : "failed");
    endtask

    task automatic test_reset_basic();
        int e;
        e = errors;
        @(negedge a_clk);
        for (int p = 0; p < 2; p++) begin
            check_true(!awready[p] && !wready[p] && !bvalid[p] && !arready[p] && !rvalid[p],
                       "a ready or valid output is high after reset");
        end
        axil_read(0, 10'h010);
        axil_write(0, 10'h010, 32'hdeadbeef, 4'hf);
        axil_read(0, 10'h010);
        report("reset_basic", e);
    endtask

    task automatic test_strobes();
        int e;
        axil_data_t got;
        e = errors;
        axil_write(0, 10'h040, 32'h11223344, 4'hf);
        axil_write(0, 10'h041, 32'haabbccdd, 4'b0101);
        axil_read(0, 10'h043);
        axil_write(1, 10'h042, 32'h55667788, 4'b1000);
        // lanes from three writes merged into one word
        @(posedge a_clk);
        start_read(0, 10'h040);
        finish_read(0, got);
        check_value("rdata", 0, got, 32'h55bb33dd);
        report("strobes", e);
    endtask

    task automatic test_cross_port();
        int e;
        e = errors;
        axil_write(1, 10'h080, 32'hcafe0001, 4'hf);
        axil_read(0, 10'h080);
        axil_write(0, 10'h084, 32'hcafe0002, 4'hf);
        axil_read(1, 10'h084);
        report("cross_port", e);
    endtask

    task automatic test_backpressure();
        int e;
        axil_data_t held;
        e = errors;
        @(posedge a_clk);
        bready[0] <= 1'b0;
        start_write(0, 10'h100, 32'h0000aaaa, 4'hf);
        finish_write(0);
        // second write waits behind the unaccepted response
        start_write(0, 10'h104, 32'h0000bbbb, 4'hf);
        repeat (4) begin
            @(negedge a_clk);
            check_true(bvalid[0] && !awready[0], "bvalid dropped or write taken while bready low");
            @(posedge a_clk);
        end
        bready[0] <= 1'b1;
        finish_write(0);
        @(posedge a_clk);
        rready[0] <= 1'b0;
        start_read(0, 10'h100);
        finish_read(0, held);
        repeat (4) begin
            @(negedge a_clk);
            check_true(rvalid[0], "rvalid dropped while rready low");
            check_value("rdata", 0, rdata[0], held);
            @(posedge a_clk);
        end
        rready[0] <= 1'b1;
        @(negedge a_clk);
        @(negedge a_clk);
        check_true(!rvalid[0], "rvalid still high after rready");
        check_value("rdata", 0, held, model[word_index(10'h100)]);
        report("backpressure", e);
    endtask

    task automatic test_mix();
        int e;
        axil_data_t old_word;
        axil_data_t got;
        logic write_first;
        e = errors;
        for (int k = 0; k < 2; k++) begin
            if (k == 1) begin
                // lone write so the next pair starts with the read
                axil_write(0, 10'h1f0, 32'h0, 4'hf);
            end
            old_word = model[word_index(10'h0c0)];
            write_first = last_read[0];
            @(posedge a_clk);
            start_write(0, 10'h0c0, 32'h12340000 + k, 4'hf);
            start_read(0, 10'h0c0);
            fork
                finish_write(0);
                finish_read(0, got);
            join
            check_value("rdata", 0, got, write_first ? model[word_index(10'h0c0)] : old_word);
            last_read[0] = write_first;
        end
        report("mix", e);
    endtask

    task automatic test_random();
        int e;
        logic [1:0] op;
        axil_addr_t addr [2];
        axil_data_t data [2];
        axil_strb_t strb [2];
        e = errors;
        for (int i = 0; i < 40; i++) begin
            op = 2'(rand_bits(2));
            for (int p = 0; p < 2; p++) begin
                // port A in the low half, port B in the high half
                addr[p] = axil_addr_t'(rand_bits($bits(axil_addr_t) - 1));
                addr[p][$bits(axil_addr_t)-1] = p[0];
                data[p] = rand_bits(32);
                strb[p] = axil_strb_t'(rand_bits(4));
            end
            fork
                run_op(0, op[0], addr[0], data[0], strb[0]);
                run_op(1, op[1], addr[1], data[1], strb[1]);
            join
        end
        report("random", e);
    endtask

    initial begin
        a_rst = 1'b1;
        for (int p = 0; p < 2; p++) begin
            awaddr[p] = '0;
            awvalid[p] = 1'b0;
            wdata[p] = '0;
            wstrb[p] = '0;
            wvalid[p] = 1'b0;
            bready[p] = 1'b1;
            araddr[p] = '0;
            arvalid[p] = 1'b0;
            rready[p] = 1'b1;
            last_read[p] = 1'b1;
        end
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (5) @(posedge a_clk);
        a_rst <= 1'b0;
        test_reset_basic();
        test_strobes();
        test_cross_port();
        test_backpressure();
        test_mix();
        test_random();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
// Free-running testbench clock with a period of 100 time units
module tb_clock (
    output logic a_clk
);

    initial begin
        a_clk = 1'b0;
        forever begin
            #50 a_clk = ~a_clk;
        end
    end

endmodule

/* hw/axil_dp_ram.sv */
// Dual-port AXI4-Lite RAM top level with flat A and B slave ports on one clock
`include "axil_ram_cfg.svh"

module axil_dp_ram (
    input  logic                     a_clk,
    input  logic                     a_rst,
    // port A
    input  axil_ram_pkg::axil_addr_t a_awaddr,
    input  logic                     a_awvalid,
    output logic                     a_awready,
    input  axil_ram_pkg::axil_data_t a_wdata,
    input  axil_ram_pkg::axil_strb_t a_wstrb,
    input  logic                     a_wvalid,
    output logic                     a_wready,
    output axil_ram_pkg::axil_resp_t a_bresp,
    output logic                     a_bvalid,
    input  logic                     a_bready,
    input  axil_ram_pkg::axil_addr_t a_araddr,
    input  logic                     a_arvalid,
    output logic                     a_arready,
    output axil_ram_pkg::axil_data_t a_rdata,
    output axil_ram_pkg::axil_resp_t a_rresp,
    output logic                     a_rvalid,
    input  logic                     a_rready,
    // port B
    input  axil_ram_pkg::axil_addr_t b_awaddr,
    input  logic                     b_awvalid,
    output logic                     b_awready,
    input  axil_ram_pkg::axil_data_t b_wdata,
    input  axil_ram_pkg::axil_strb_t b_wstrb,
    input  logic                     b_wvalid,
    output logic                     b_wready,
    output axil_ram_pkg::axil_resp_t b_bresp,
    output logic                     b_bvalid,
    input  logic                     b_bready,
    input  axil_ram_pkg::axil_addr_t b_araddr,
    input  logic                     b_arvalid,
    output logic                     b_arready,
    output axil_ram_pkg::axil_data_t b_rdata,
    output axil_ram_pkg::axil_resp_t b_rresp,
    output logic                     b_rvalid,
    input  logic                     b_rready
);

    axil_if wr_a_bus ();
    axil_if rd_a_bus ();
    axil_if wr_b_bus ();
    axil_if rd_b_bus ();

    ram_port_if mem_a_bus ();
    ram_port_if mem_b_bus ();

    // port A wiring
    assign wr_a_bus.awaddr = a_awaddr;
    assign wr_a_bus.awvalid = a_awvalid;
    assign wr_a_bus.wdata = a_wdata;
    assign wr_a_bus.wstrb = a_wstrb;
    assign wr_a_bus.wvalid = a_wvalid;
    assign wr_a_bus.bready = a_bready;
    assign a_awready = wr_a_bus.awready;
    assign a_wready = wr_a_bus.wready;
    assign a_bresp = wr_a_bus.bresp;
    assign a_bvalid = wr_a_bus.bvalid;
    assign rd_a_bus.araddr = a_araddr;
    assign rd_a_bus.arvalid = a_arvalid;
    assign rd_a_bus.rready = a_rready;
    assign a_arready = rd_a_bus.arready;
    assign a_rdata = rd_a_bus.rdata;
    assign a_rresp = rd_a_bus.rresp;
    assign a_rvalid = rd_a_bus.rvalid;

    // port B wiring
    assign wr_b_bus.awaddr = b_awaddr;
    assign wr_b_bus.awvalid = b_awvalid;
    assign wr_b_bus.wdata = b_wdata;
    assign wr_b_bus.wstrb = b_wstrb;
    assign wr_b_bus.wvalid = b_wvalid;
    assign wr_b_bus.bready = b_bready;
    assign b_awready = wr_b_bus.awready;
    assign b_wready = wr_b_bus.wready;
    assign b_bresp = wr_b_bus.bresp;
    assign b_bvalid = wr_b_bus.bvalid;
    assign rd_b_bus.araddr = b_araddr;
    assign rd_b_bus.arvalid = b_arvalid;
    assign rd_b_bus.rready = b_rready;
    assign b_arready = rd_b_bus.arready;
    assign b_rdata = rd_b_bus.rdata;
    assign b_rresp = rd_b_bus.rresp;
    assign b_rvalid = rd_b_bus.rvalid;

    axil_ram_port #(
        .pipeline_output(`AXIL_RAM_PIPELINE_OUTPUT)
    ) i_port_a (
        .a_clk(a_clk),
        .a_rst(a_rst),
        .s_wr (wr_a_bus),
        .s_rd (rd_a_bus),
        .mem  (mem_a_bus)
    );

    axil_ram_port #(
        .pipeline_output(`AXIL_RAM_PIPELINE_OUTPUT)
    ) i_port_b (
        .a_clk(a_clk),
        .a_rst(a_rst),
        .s_wr (wr_b_bus),
        .s_rd (rd_b_bus),
        .mem  (mem_b_bus)
    );

    dp_ram_core i_core (
        .a_clk (a_clk),
        .port_a(mem_a_bus),
        .port_b(mem_b_bus)
    );

endmodule

/* hw/dp_ram_core.sv */
// Shared word array with two independent access ports, byte-lane writes and one-cycle reads
module dp_ram_core (
    input  logic    a_clk,
    ram_port_if.mem port_a,
    ram_port_if.mem port_b
);
    import axil_ram_pkg::*;

    localparam int mem_words = 2 ** $bits(mem_index_t);

    axil_data_t mem_array [mem_words] = '{default: '0};
    axil_data_t rdata_a_reg;
    axil_data_t rdata_b_reg;

    // one process for both ports, same-word collisions are undefined
    always_ff @(posedge a_clk) begin
        for (int i = 0; i < byte_lanes; i++) begin
            if (port_a.wr_en && port_a.wstrb[i]) begin
                mem_array[port_a.index][8*i +: 8] <= port_a.wdata[8*i +: 8];
            end
            if (port_b.wr_en && port_b.wstrb[i]) begin
                mem_array[port_b.index][8*i +: 8] <= port_b.wdata[8*i +: 8];
            end
        end

        if (port_a.rd_en) begin
            rdata_a_reg <= mem_array[port_a.index];
        end
        if (port_b.rd_en) begin
            rdata_b_reg <= mem_array[port_b.index];
        end
    end

    assign port_a.rdata = rdata_a_reg;
    assign port_b.rdata = rdata_b_reg;

endmodule

/* hw/axil_ram_port.sv */
// AXI4-Lite slave controller for one RAM port; instantiate once per port in front of the core
module axil_ram_port #(
    parameter bit pipeline_output = 1'b0
) (
    input  logic     a_clk,
    input  logic     a_rst,
    axil_if.wr_slv   s_wr,
    axil_if.rd_slv   s_rd,
    ram_port_if.ctrl mem
);
    import axil_ram_pkg::*;

    logic wr_eligible;
    logic rd_eligible;
    logic wr_grant;
    logic rd_grant;
    logic stage_adv;
    logic out_free;

    mem_index_t aw_index;
    mem_index_t ar_index;

    logic last_read_reg;
    logic awready_reg;
    logic wready_reg;
    logic bvalid_reg;
    logic arready_reg;
    logic rvalid_reg;
    logic rvalid_pipe_reg;
    axil_data_t rdata_pipe_reg;

    // word index, byte offset bits dropped
    assign aw_index = mem_index_t'(s_wr.awaddr >> lane_bits);
    assign ar_index = mem_index_t'(s_rd.araddr >> lane_bits);

    // first stage empties when the master takes it or the pipe register is free
    assign stage_adv = s_rd.rready || (pipeline_output && !rvalid_pipe_reg);
    assign out_free = !rvalid_reg || stage_adv;

    assign wr_eligible = s_wr.awvalid && s_wr.wvalid && (!bvalid_reg || s_wr.bready)
                         && !awready_reg && !wready_reg;
    assign rd_eligible = s_rd.arvalid && out_free && !arready_reg;

    // alternate when both are waiting, write first after reset
    assign wr_grant = wr_eligible && (!rd_eligible || last_read_reg);
    assign rd_grant = rd_eligible && !wr_grant;

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            last_read_reg <= 1'b1;
            awready_reg <= 1'b0;
            wready_reg <= 1'b0;
            bvalid_reg <= 1'b0;
            arready_reg <= 1'b0;
            rvalid_reg <= 1'b0;
            rvalid_pipe_reg <= 1'b0;
        end else begin
            awready_reg <= wr_grant;
            wready_reg <= wr_grant;
            arready_reg <= rd_grant;

            if (wr_grant) begin
                last_read_reg <= 1'b0;
            end else if (rd_grant) begin
                last_read_reg <= 1'b1;
            end

            if (wr_grant) begin
                bvalid_reg <= 1'b1;
            end else if (s_wr.bready) begin
                bvalid_reg <= 1'b0;
            end

            if (rd_grant) begin
                rvalid_reg <= 1'b1;
            end else if (stage_adv) begin
                rvalid_reg <= 1'b0;
            end

            if (!rvalid_pipe_reg || s_rd.rready) begin
                rvalid_pipe_reg <= rvalid_reg;
            end
        end
    end

    // second output word, loaded alongside its valid flag
    always_ff @(posedge a_clk) begin
        if (!rvalid_pipe_reg || s_rd.rready) begin
            rdata_pipe_reg <= mem.rdata;
        end
    end

    assign mem.wr_en = wr_grant;
    assign mem.rd_en = rd_grant;
    assign mem.index = rd_grant ? ar_index : aw_index;
    assign mem.wdata = s_wr.wdata;
    assign mem.wstrb = s_wr.wstrb;

    assign s_wr.awready = awready_reg;
    assign s_wr.wready = wready_reg;
    assign s_wr.bresp = resp_okay;
    assign s_wr.bvalid = bvalid_reg;

    assign s_rd.arready = arready_reg;
    assign s_rd.rdata = pipeline_output ? rdata_pipe_reg : mem.rdata;
    assign s_rd.rresp = resp_okay;
    assign s_rd.rvalid = pipeline_output ? rvalid_pipe_reg : rvalid_reg;

endmodule

/* hw/ram_port_if.sv */
// One fixed-latency access port between a port controller and the shared word array
interface ram_port_if;
    import axil_ram_pkg::*;

    logic       wr_en;
    logic       rd_en;
    mem_index_t index;
    axil_data_t wdata;
    axil_strb_t wstrb;
    // valid the cycle after rd_en, held until the next read
    axil_data_t rdata;

    modport ctrl (output wr_en, rd_en, index, wdata, wstrb, input rdata);
    modport mem (input wr_en, rd_en, index, wdata, wstrb, output rdata);

endinterface

/* hw/axil_if.sv */
// AXI4-Lite channel bundle; use one instance per direction with the matching modport pair
interface axil_if;
    import axil_ram_pkg::*;

    // write address, write data and write response
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;

    // read address and read data
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;

    modport wr_slv (input awaddr, awvalid, wdata, wstrb, wvalid, bready,
                    output awready, wready, bresp, bvalid);
    modport wr_mst (output awaddr, awvalid, wdata, wstrb, wvalid, bready,
                    input awready, wready, bresp, bvalid);
    modport rd_slv (input araddr, arvalid, rready, output arready, rdata, rresp, rvalid);
    modport rd_mst (output araddr, arvalid, rready, input arready, rdata, rresp, rvalid);

endinterface

/* hw/axil_ram_pkg.sv */
// Shared bus and memory types for the dual-port RAM; import into any module that uses them
`include "axil_ram_cfg.svh"

package axil_ram_pkg;

    localparam int byte_lanes = `AXIL_RAM_DATA_W / 8;
    localparam int lane_bits = $clog2(byte_lanes);

    typedef logic [`AXIL_RAM_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_RAM_DATA_W-1:0] axil_data_t;
    typedef logic [byte_lanes-1:0] axil_strb_t;
    typedef logic [1:0] axil_resp_t;
    typedef logic [`AXIL_RAM_ADDR_W-lane_bits-1:0] mem_index_t;

    localparam axil_resp_t resp_okay = 2'b00;

endpackage

/* hw/axil_ram_cfg.svh */
// Build-time sizes for the dual-port AXI4-Lite RAM; include wherever the macros are needed
`ifndef AXIL_RAM_CFG_SVH
`define AXIL_RAM_CFG_SVH

// byte address width, sets the array depth
`define AXIL_RAM_ADDR_W 10

`define AXIL_RAM_DATA_W 32

// 1 adds a read output register on both ports
`define AXIL_RAM_PIPELINE_OUTPUT 0

`endif
